// ==== Bender.yml ====
package:
  name: clct_finder

sources:
  - clct_pkg.sv
  - clct_wb_regs.sv
  - pattern_match.sv
  - best_1of32.sv
  - clct_finder_top.sv
  - target: simulation
    files:
      - tb_clct_finder.sv

// ==== best_1of32.sv ====
module best_1of32 (
  input  logic                                                clock,
  input  logic                                                rst_n,
  input  logic [clct_pkg::n_keys-1:0][clct_pkg::pat_bits-1:0] key_pat,
  input  logic [clct_pkg::n_keys-1:0][clct_pkg::cc_bits-1:0]  key_cc,
  input  logic                                                key_valid,
  output logic [clct_pkg::pat_bits-1:0]                       best_pat,
  output logic [clct_pkg::key_bits-1:0]                       best_key,
  output logic [clct_pkg::cc_bits-1:0]                        best_cc,
  output logic                                                best_valid
);

  // Level 0 holds the inputs and levels 1 to 3 keep 16, 8 and 4
  logic [clct_pkg::pat_bits-1:0] pat_t [4][clct_pkg::n_keys];
  logic [clct_pkg::key_bits-1:0] key_t [4][clct_pkg::n_keys];
  logic [clct_pkg::cc_bits-1:0]  cc_t  [4][clct_pkg::n_keys];

  // Best 2 of 4 as next value and as pipeline register
  // The top key bit is added by the final compare
  logic [clct_pkg::pat_bits-1:0] pat_d [2];
  logic [clct_pkg::key_bits-2:0] key_d [2];
  logic [clct_pkg::cc_bits-1:0]  cc_d  [2];
  logic [clct_pkg::pat_bits-1:0] pat_p [2];
  logic [clct_pkg::key_bits-2:0] key_p [2];
  logic [clct_pkg::cc_bits-1:0]  cc_p  [2];
  logic                          valid_p;
  logic                          odd_last;

  // Odd entry must be strictly better, so ties keep the lower key
  function automatic logic odd_wins(
    input logic [clct_pkg::pat_bits-1:0] even_pat,
    input logic [clct_pkg::pat_bits-1:0] odd_pat
  );
    return odd_pat > even_pat;
  endfunction

  // ----------------------------------------------------------------------
  // Compare-by-twos down to 4 and then the 2 of 4 compare
  // ----------------------------------------------------------------------
  always_comb begin : tree
    logic odd;
    pat_t = '{default: '0};
    key_t = '{default: '0};
    cc_t  = '{default: '0};
    for (int i = 0; i < clct_pkg::n_keys; i++) begin
      pat_t[0][i] = key_pat[i];
      cc_t[0][i]  = key_cc[i];
    end
    // Each level appends its key bit above those already set
    for (int lvl = 1; lvl < 4; lvl++) begin
      for (int i = 0; i < (clct_pkg::n_keys >> lvl); i++) begin
        odd = odd_wins(pat_t[lvl-1][2*i], pat_t[lvl-1][2*i+1]);
        pat_t[lvl][i] = odd ? pat_t[lvl-1][2*i+1] : pat_t[lvl-1][2*i];
        cc_t[lvl][i]  = odd ? cc_t[lvl-1][2*i+1] : cc_t[lvl-1][2*i];
        // The first level has no lower key bits to carry
        if (lvl > 1) begin
          key_t[lvl][i] = odd ? key_t[lvl-1][2*i+1] : key_t[lvl-1][2*i];
        end
        key_t[lvl][i][lvl-1] = odd;
      end
    end
    for (int i = 0; i < 2; i++) begin
      odd = odd_wins(pat_t[3][2*i], pat_t[3][2*i+1]);
      pat_d[i] = odd ? pat_t[3][2*i+1] : pat_t[3][2*i];
      key_d[i] = {odd, odd ? key_t[3][2*i+1][2:0] : key_t[3][2*i][2:0]};
      cc_d[i]  = odd ? cc_t[3][2*i+1] : cc_t[3][2*i];
    end
  end

  always_ff @(posedge clock) begin
    pat_p <= pat_d;
    key_p <= key_d;
    cc_p  <= cc_d;
  end

  // Final 1 of 2 into the output register
  assign odd_last = odd_wins(pat_p[0], pat_p[1]);

  always_ff @(posedge clock) begin
    best_pat <= odd_last ? pat_p[1] : pat_p[0];
    best_key <= {odd_last, odd_last ? key_p[1] : key_p[0]};
    best_cc  <= odd_last ? cc_p[1] : cc_p[0];
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      valid_p    <= 1'b0;
      best_valid <= 1'b0;
    end else begin
      valid_p    <= key_valid;
      best_valid <= valid_p;
    end
  end

endmodule

// ==== clct_finder_top.sv ====
module clct_finder_top (
  input  logic                              clock,
  input  logic                              rst_n,
  input  logic                              wb_cyc,
  input  logic                              wb_stb,
  input  logic                              wb_we,
  input  logic [clct_pkg::wb_addr_bits-1:0] wb_adr,
  input  logic [clct_pkg::wb_data_bits-1:0] wb_dat_w,
  output logic [clct_pkg::wb_data_bits-1:0] wb_dat_r,
  output logic                              wb_ack
);

  logic [clct_pkg::n_layers-1:0][clct_pkg::n_keys-1:0] layer_hits;
  logic                                                start;

  // Per-key results out of the first stage
  logic [clct_pkg::n_keys-1:0][clct_pkg::pat_bits-1:0] key_pat;
  logic [clct_pkg::n_keys-1:0][clct_pkg::cc_bits-1:0]  key_cc;
  logic                                                key_valid;

  // Winner out of the sorter
  logic [clct_pkg::pat_bits-1:0] best_pat;
  logic [clct_pkg::key_bits-1:0] best_key;
  logic [clct_pkg::cc_bits-1:0]  best_cc;
  logic                          best_valid;

  clct_wb_regs regs_i (
    .clock      (clock),
    .rst_n      (rst_n),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .layer_hits (layer_hits),
    .start      (start),
    .best_pat   (best_pat),
    .best_key   (best_key),
    .best_cc    (best_cc),
    .best_valid (best_valid)
  );

  pattern_match match_i (
    .clock      (clock),
    .rst_n      (rst_n),
    .layer_hits (layer_hits),
    .start      (start),
    .key_pat    (key_pat),
    .key_cc     (key_cc),
    .key_valid  (key_valid)
  );

  best_1of32 sort_i (
    .clock      (clock),
    .rst_n      (rst_n),
    .key_pat    (key_pat),
    .key_cc     (key_cc),
    .key_valid  (key_valid),
    .best_pat   (best_pat),
    .best_key   (best_key),
    .best_cc    (best_cc),
    .best_valid (best_valid)
  );

endmodule

// ==== clct_pkg.sv ====
package clct_pkg;

  // ----------------------------------------------------------------------
  // Chamber geometry
  // ----------------------------------------------------------------------
  localparam int n_layers = 6;
  localparam int n_keys   = 32;
  localparam int key_bits = 5;

  // Pattern word is the hit count above the pattern id
  localparam int hit_bits   = 3;
  localparam int id_bits    = 4;
  localparam int pat_bits   = hit_bits + id_bits;
  localparam int n_patterns = 5;

  // Two comparator bits per layer, layer 0 lowest
  localparam int cc_bits = 2 * n_layers;

  localparam logic [1:0] cc_none   = 2'd0;
  localparam logic [1:0] cc_left   = 2'd1;
  localparam logic [1:0] cc_centre = 2'd2;
  localparam logic [1:0] cc_right  = 2'd3;

  // Window centre offsets in half-strips, one row per pattern id
  // Layer 2 is the key layer and never moves
  localparam int pattern_offset [n_patterns][n_layers] = '{
    '{ 2,  1,  0, -1, -2, -3},
    '{-2, -1,  0,  1,  2,  3},
    '{ 1,  1,  0,  0, -1, -1},
    '{-1, -1,  0,  0,  1,  1},
    '{ 0,  0,  0,  0,  0,  0}
  };

  // ----------------------------------------------------------------------
  // Wishbone register map
  // ----------------------------------------------------------------------
  localparam int wb_addr_bits = 4;
  localparam int wb_data_bits = 32;

  localparam logic [wb_addr_bits-1:0] addr_layer0 = 4'd0;
  localparam logic [wb_addr_bits-1:0] addr_layer1 = 4'd1;
  localparam logic [wb_addr_bits-1:0] addr_layer2 = 4'd2;
  localparam logic [wb_addr_bits-1:0] addr_layer3 = 4'd3;
  localparam logic [wb_addr_bits-1:0] addr_layer4 = 4'd4;
  localparam logic [wb_addr_bits-1:0] addr_layer5 = 4'd5;
  localparam logic [wb_addr_bits-1:0] addr_start  = 4'd6;
  localparam logic [wb_addr_bits-1:0] addr_result = 4'd8;

  // Result register fields, comparator code sits at bit 0
  localparam int result_valid_bit = 24;
  localparam int result_pat_lsb   = 17;
  localparam int result_key_lsb   = 12;

endpackage

// ==== clct_tests.txt ====
# name mode layer0 layer1 layer2 layer3 layer4 layer5 pattern key comparator_code
# Mode is decimal, 1 reruns the loaded image and starts this one right behind it; rest is hex
#
# Straight track, the lowest key that sees all six layers wins
straight_k13     0 00002000 00002000 00002000 00002000 00002000 00002000 64 0c fff
#
# Bent tracks with one layer missing
bend_right       0 00040000 00040000 00100000 00100000 00400000 00000000 53 14 3a5
bend_left        0 00000000 00000800 00000200 00000200 00000080 00000080 52 09 5ac
steep_right      0 00004000 00000000 00010000 00020000 00040000 00080000 51 0f ff3
steep_left       0 00000100 00000080 00000040 00000020 00000000 00000008 50 05 cff
#
# Equal words go to the lower key, a higher id wins at equal hits
tie_low_key      0 02000020 02000020 02000020 02000020 02000020 02000020 64 04 fff
b2b_second       1 02000000 02000020 02000020 02000020 02000020 02000020 64 18 fff
id_beats_id      0 00400010 00400000 01000040 01000080 04000100 00000200 53 18 3a5
#
# Empty, full and edge images
empty            0 00000000 00000000 00000000 00000000 00000000 00000000 00 00 000
all_hits         0 ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff 64 00 aaa
edge_key0        0 00000001 00000001 00000001 00000001 00000001 00000001 64 00 aaa
edge_right_steep 0 20000000 40000000 80000000 00000000 00000000 00000000 34 1e 039
single_hit       0 00000000 00000000 00000000 00000400 00000000 00000000 14 09 0c0

// ==== clct_wb_regs.sv ====
module clct_wb_regs (
  input  logic                                                clock,
  input  logic                                                rst_n,
  input  logic                                                wb_cyc,
  input  logic                                                wb_stb,
  input  logic                                                wb_we,
  input  logic [clct_pkg::wb_addr_bits-1:0]                   wb_adr,
  input  logic [clct_pkg::wb_data_bits-1:0]                   wb_dat_w,
  output logic [clct_pkg::wb_data_bits-1:0]                   wb_dat_r,
  output logic                                                wb_ack,
  output logic [clct_pkg::n_layers-1:0][clct_pkg::n_keys-1:0] layer_hits,
  output logic                                                start,
  input  logic [clct_pkg::pat_bits-1:0]                       best_pat,
  input  logic [clct_pkg::key_bits-1:0]                       best_key,
  input  logic [clct_pkg::cc_bits-1:0]                        best_cc,
  input  logic                                                best_valid
);

  logic                           wb_write;
  logic                           start_write;
  logic                           result_valid;
  logic [clct_pkg::pat_bits-1:0]  result_pat;
  logic [clct_pkg::key_bits-1:0]  result_key;
  logic [clct_pkg::cc_bits-1:0]   result_cc;
  logic [clct_pkg::wb_data_bits-1:0] result_word;

  // Writes commit at the end of the ack cycle
  assign wb_write    = wb_ack & wb_cyc & wb_stb & wb_we;
  assign start_write = wb_write && (wb_adr == clct_pkg::addr_start);

  // ----------------------------------------------------------------------
  // Single-cycle ack, never two in a row
  // ----------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      wb_ack <= 1'b0;
      start  <= 1'b0;
    end else begin
      wb_ack <= wb_cyc & wb_stb & ~wb_ack;
      start  <= start_write;
    end
  end

  // Layer hit images
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      layer_hits <= '0;
    end else if (wb_write) begin
      case (wb_adr)
        clct_pkg::addr_layer0: layer_hits[0] <= wb_dat_w;
        clct_pkg::addr_layer1: layer_hits[1] <= wb_dat_w;
        clct_pkg::addr_layer2: layer_hits[2] <= wb_dat_w;
        clct_pkg::addr_layer3: layer_hits[3] <= wb_dat_w;
        clct_pkg::addr_layer4: layer_hits[4] <= wb_dat_w;
        clct_pkg::addr_layer5: layer_hits[5] <= wb_dat_w;
        default: ;
      endcase
    end
  end

  // A new start hides the old result until the next winner lands
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      result_valid <= 1'b0;
    end else if (start_write) begin
      result_valid <= 1'b0;
    end else if (best_valid) begin
      result_valid <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (best_valid) begin
      result_pat <= best_pat;
      result_key <= best_key;
      result_cc  <= best_cc;
    end
  end

  // ----------------------------------------------------------------------
  // Read mux
  // ----------------------------------------------------------------------
  always_comb begin
    result_word = '0;
    result_word[clct_pkg::result_valid_bit] = result_valid;
    result_word[clct_pkg::result_pat_lsb +: clct_pkg::pat_bits] = result_pat;
    result_word[clct_pkg::result_key_lsb +: clct_pkg::key_bits] = result_key;
    result_word[0 +: clct_pkg::cc_bits] = result_cc;
  end

  always_comb begin
    wb_dat_r = '0;
    case (wb_adr)
      clct_pkg::addr_layer0: wb_dat_r = layer_hits[0];
      clct_pkg::addr_layer1: wb_dat_r = layer_hits[1];
      clct_pkg::addr_layer2: wb_dat_r = layer_hits[2];
      clct_pkg::addr_layer3: wb_dat_r = layer_hits[3];
      clct_pkg::addr_layer4: wb_dat_r = layer_hits[4];
      clct_pkg::addr_layer5: wb_dat_r = layer_hits[5];
      clct_pkg::addr_result: wb_dat_r = result_word;
      default: ;
    endcase
  end

endmodule

// ==== flist.f ====
clct_pkg.sv
clct_wb_regs.sv
pattern_match.sv
best_1of32.sv
clct_finder_top.sv
tb_clct_finder.sv

// ==== pattern_match.sv ====
module pattern_match (
  input  logic                                                clock,
  input  logic                                                rst_n,
  input  logic [clct_pkg::n_layers-1:0][clct_pkg::n_keys-1:0] layer_hits,
  input  logic                                                start,
  output logic [clct_pkg::n_keys-1:0][clct_pkg::pat_bits-1:0] key_pat,
  output logic [clct_pkg::n_keys-1:0][clct_pkg::cc_bits-1:0]  key_cc,
  output logic                                                key_valid
);

  logic [clct_pkg::n_keys-1:0][clct_pkg::pat_bits-1:0] pat_next;
  logic [clct_pkg::n_keys-1:0][clct_pkg::cc_bits-1:0]  cc_next;

  // Half-strips off either end of the group read as empty
  function automatic logic cell_at(
    input logic [clct_pkg::n_keys-1:0] hits,
    input int                          pos
  );
    logic value;
    value = 1'b0;
    if (pos >= 0 && pos < clct_pkg::n_keys) begin
      value = hits[pos];
    end
    return value;
  endfunction

  // Three-cell window, centre wins over left (lower strip) over right
  function automatic logic [1:0] window_code(
    input logic [clct_pkg::n_keys-1:0] hits,
    input int                          centre
  );
    logic [1:0] code;
    if (cell_at(hits, centre)) begin
      code = clct_pkg::cc_centre;
    end else if (cell_at(hits, centre - 1)) begin
      code = clct_pkg::cc_left;
    end else if (cell_at(hits, centre + 1)) begin
      code = clct_pkg::cc_right;
    end else begin
      code = clct_pkg::cc_none;
    end
    return code;
  endfunction

  // ----------------------------------------------------------------------
  // Score all patterns at every key
  // ----------------------------------------------------------------------
  always_comb begin : score
    logic [1:0]                    code;
    logic [clct_pkg::hit_bits-1:0] hits_now;
    logic [clct_pkg::cc_bits-1:0]  cc_now;
    logic [clct_pkg::hit_bits-1:0] best_hits;
    logic [clct_pkg::id_bits-1:0]  best_id;
    logic [clct_pkg::cc_bits-1:0]  best_cc;

    for (int key = 0; key < clct_pkg::n_keys; key++) begin
      best_hits = '0;
      best_id   = '0;
      best_cc   = '0;
      // Ascending ids with >= so a tie goes to the higher id
      for (int pid = 0; pid < clct_pkg::n_patterns; pid++) begin
        hits_now = '0;
        cc_now   = '0;
        for (int layer = 0; layer < clct_pkg::n_layers; layer++) begin
          code = window_code(layer_hits[layer],
                             key + clct_pkg::pattern_offset[pid][layer]);
          cc_now[2*layer +: 2] = code;
          if (code != clct_pkg::cc_none) begin
            hits_now = hits_now + 1'b1;
          end
        end
        // Empty keys keep an all-zero word
        if (hits_now != '0 && hits_now >= best_hits) begin
          best_hits = hits_now;
          best_id   = clct_pkg::id_bits'(pid);
          best_cc   = cc_now;
        end
      end
      pat_next[key] = {best_hits, best_id};
      cc_next[key]  = best_cc;
    end
  end

  // ----------------------------------------------------------------------
  // Stage register, loaded by the start pulse
  // ----------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (start) begin
      key_pat <= pat_next;
      key_cc  <= cc_next;
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      key_valid <= 1'b0;
    end else begin
      key_valid <= start;
    end
  end

endmodule

// ==== tb_clct_finder.sv ====
module tb_clct_finder;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int max_tests    = 64;
  localparam int reset_cycles = 16;
  localparam int test_cycles  = 60;

  logic                              clock;
  logic                              rst_n;
  logic                              wb_cyc;
  logic                              wb_stb;
  logic                              wb_we;
  logic [clct_pkg::wb_addr_bits-1:0] wb_adr;
  logic [clct_pkg::wb_data_bits-1:0] wb_dat_w;
  logic [clct_pkg::wb_data_bits-1:0] wb_dat_r;
  logic                              wb_ack;

  // Test vectors as read from the tests file
  string       test_name  [max_tests];
  int          test_mode  [max_tests];
  logic [31:0] test_layer [max_tests][clct_pkg::n_layers];
  logic [31:0] test_pat   [max_tests];
  logic [31:0] test_key   [max_tests];
  logic [31:0] test_cc    [max_tests];

  // Mirror of the layer registers inside the DUT
  logic [31:0] loaded [clct_pkg::n_layers];

  int n_tests;
  int error_count;
  int failed_tests;
  int cycle_count;
  int cycle_limit;

  clct_finder_top dut_i (
    .clock    (clock),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // Watchdog, the limit is set once the tests are loaded
  always @(posedge clock) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
      $display("Error: result never became valid within %0d cycles", cycle_limit);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // Wishbone master, called on a falling edge
  // ----------------------------------------------------------------------
  task automatic wait_for_ack();
    do begin
      @(negedge clock);
    end while (wb_ack !== 1'b1);
  endtask

  task automatic write_reg(input logic [clct_pkg::wb_addr_bits-1:0] adr,
                           input logic [31:0] data);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_dat_w = data;
    wait_for_ack();
    // Hold the cycle through the ack edge so the write commits
    @(negedge clock);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic read_reg(input logic [clct_pkg::wb_addr_bits-1:0] adr,
                          output logic [31:0] data);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    wait_for_ack();
    data = wb_dat_r;
    @(negedge clock);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  task automatic check_value(input string name, input string field,
                             input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Mismatch %s %s: expected %h, actual %h", name, field, expected, actual);
      error_count++;
    end
  endtask

  // ----------------------------------------------------------------------
  // Tests file
  // ----------------------------------------------------------------------
  task automatic load_tests();
    int          fd;
    int          count;
    int          mode;
    string       line;
    string       name;
    logic [31:0] lv [clct_pkg::n_layers];
    logic [31:0] pat;
    logic [31:0] key;
    logic [31:0] cc;
    fd = $fopen("clct_tests.txt", "r");
    if (fd == 0) begin
      $display("Error: cannot open clct_tests.txt");
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      count = $sscanf(line, "%s %d %h %h %h %h %h %h %h %h %h", name, mode,
                      lv[0], lv[1], lv[2], lv[3], lv[4], lv[5], pat, key, cc);
      if (count != 11 || n_tests >= max_tests) begin
        $display("Error: unreadable or surplus line in the tests file: %s", line);
        error_count++;
      end else begin
        test_name[n_tests] = name;
        test_mode[n_tests] = mode;
        for (int layer = 0; layer < clct_pkg::n_layers; layer++) begin
          test_layer[n_tests][layer] = lv[layer];
        end
        test_pat[n_tests] = pat;
        test_key[n_tests] = key;
        test_cc[n_tests]  = cc;
        n_tests++;
      end
    end
    $fclose(fd);
  endtask

  task automatic run_test(input int idx);
    logic [31:0]                       result;
    logic [31:0]                       readback;
    logic [clct_pkg::wb_addr_bits-1:0] adr;
    int                                errors_before;
    errors_before = error_count;
    // Mode 1 reruns the loaded image so two searches overlap
    if (test_mode[idx] == 1) begin
      write_reg(clct_pkg::addr_start, 32'h1);
    end
    for (int layer = 0; layer < clct_pkg::n_layers; layer++) begin
      if (test_mode[idx] == 0 || test_layer[idx][layer] !== loaded[layer]) begin
        adr = clct_pkg::addr_layer0 + layer[clct_pkg::wb_addr_bits-1:0];
        write_reg(adr, test_layer[idx][layer]);
        loaded[layer] = test_layer[idx][layer];
      end
    end
    write_reg(clct_pkg::addr_start, 32'h1);
    read_reg(clct_pkg::addr_result, result);
    check_value(test_name[idx], "valid after start", 32'h0,
                32'(result[clct_pkg::result_valid_bit]));
    while (result[clct_pkg::result_valid_bit] !== 1'b1) begin
      read_reg(clct_pkg::addr_result, result);
    end
    check_value(test_name[idx], "pattern", test_pat[idx],
                32'(result[clct_pkg::result_pat_lsb +: clct_pkg::pat_bits]));
    check_value(test_name[idx], "key", test_key[idx],
                32'(result[clct_pkg::result_key_lsb +: clct_pkg::key_bits]));
    check_value(test_name[idx], "comparator code", test_cc[idx],
                32'(result[0 +: clct_pkg::cc_bits]));
    for (int layer = 0; layer < clct_pkg::n_layers; layer++) begin
      adr = clct_pkg::addr_layer0 + layer[clct_pkg::wb_addr_bits-1:0];
      read_reg(adr, readback);
      check_value(test_name[idx], $sformatf("layer %0d", layer), test_layer[idx][layer],
                  readback);
    end
    if (error_count == errors_before) begin
      $display("PASS %s", test_name[idx]);
    end else begin
      $display("FAIL %s", test_name[idx]);
      failed_tests++;
    end
  endtask

  initial begin
    rst_n        = 1'b0;
    wb_cyc       = 1'b0;
    wb_stb       = 1'b0;
    wb_we        = 1'b0;
    wb_adr       = '0;
    wb_dat_w     = '0;
    n_tests      = 0;
    error_count  = 0;
    failed_tests = 0;
    cycle_count  = 0;
    cycle_limit  = 0;
    for (int layer = 0; layer < clct_pkg::n_layers; layer++) begin
      loaded[layer] = '0;
    end
    load_tests();
    cycle_limit = test_cycles * n_tests + reset_cycles;
    repeat (reset_cycles) @(negedge clock);
    rst_n = 1'b1;
    @(negedge clock);
    if (n_tests == 0) begin
      $display("Error: no tests were loaded from the tests file");
      error_count++;
    end
    for (int i = 0; i < n_tests; i++) begin
      run_test(i);
    end
    $display("Tests run: %0d, passed: %0d, failed: %0d, errors: %0d",
             n_tests, n_tests - failed_tests, failed_tests, error_count);
    if (error_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
